// File: verilog/stm_pkg.sv
package stm_pkg;

  // pattern kind played by the sequencer.
  typedef enum logic {
    STM_MODE_GAIN  = 1'b0,
    STM_MODE_FOCUS = 1'b1
  } stm_mode_t;

  // focus generator FSM.
  typedef enum logic [2:0] {
    FOCUS_IDLE,
    FOCUS_LOAD,
    FOCUS_SQUARE,
    FOCUS_ROOT,
    FOCUS_EMIT
  } focus_state_t;

  // grid spacing of transducers, in focus length units.
  localparam logic [15:0] PITCH = 16'd10;

  // repeat count that never runs out.
  localparam logic [15:0] REP_INFINITE = 16'hffff;

endpackage

// File: verilog/stm_timer.sv
`timescale 1ns/1ns
module stm_timer (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        settings_update,
  input  logic [15:0] cycle_0,
  input  logic [15:0] cycle_1,
  input  logic [15:0] freq_div_0,
  input  logic [15:0] freq_div_1,
  output logic [15:0] idx_0,
  output logic [15:0] idx_1,
  output logic        settings_update_out
);

  logic [15:0] cycle_in [2];
  logic [15:0] div_in [2];
  logic [15:0] cycle_q [2];
  logic [15:0] div_q [2];
  logic [15:0] div_cnt [2];
  logic [15:0] idx_q [2];
  logic        running;

  assign cycle_in[0] = cycle_0;
  assign cycle_in[1] = cycle_1;
  assign div_in[0]   = freq_div_0;
  assign div_in[1]   = freq_div_1;
  assign idx_0       = idx_q[0];
  assign idx_1       = idx_q[1];

  // counters hold at zero until the first settings strobe.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      running             <= 1'b0;
      settings_update_out <= 1'b0;
    end else begin
      running             <= running | settings_update;
      settings_update_out <= settings_update;
    end
  end

  for (genvar s = 0; s < 2; s++) begin : g_seg
    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        cycle_q[s] <= 16'd1;
        div_q[s]   <= 16'd1;
        div_cnt[s] <= 16'd0;
        idx_q[s]   <= 16'd0;
      end else if (settings_update) begin
        cycle_q[s] <= cycle_in[s];
        div_q[s]   <= div_in[s];
        div_cnt[s] <= 16'd0;
        idx_q[s]   <= 16'd0;
      end else if (running) begin
        if (div_cnt[s] == div_q[s] - 16'd1) begin
          div_cnt[s] <= 16'd0;
          // wrap at the segment's cycle length.
          idx_q[s]   <= (idx_q[s] == cycle_q[s] - 16'd1) ? 16'd0 : idx_q[s] + 16'd1;
        end else begin
          div_cnt[s] <= div_cnt[s] + 16'd1;
        end
      end
    end
  end

endmodule

// File: verilog/stm_swapchain.sv
`timescale 1ns/1ns
module stm_swapchain (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                settings_update,
  input  stm_pkg::stm_mode_t  req_mode,
  input  logic                req_segment,
  input  logic [15:0]         rep,
  input  logic [15:0]         idx_0_in,
  input  logic [15:0]         idx_1_in,
  output stm_pkg::stm_mode_t  mode,
  output logic                segment,
  output logic                stop,
  output logic [15:0]         idx_0_out,
  output logic [15:0]         idx_1_out
);

  import stm_pkg::*;

  logic [15:0] loop_cnt;
  logic        wrap;

  // active index went backwards.
  assign wrap = segment ? (idx_1_in < idx_1_out) : (idx_0_in < idx_0_out);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mode      <= STM_MODE_GAIN;
      segment   <= 1'b0;
      stop      <= 1'b0;
      loop_cnt  <= REP_INFINITE;
      idx_0_out <= 16'd0;
      idx_1_out <= 16'd0;
    end else if (settings_update) begin
      mode      <= req_mode;
      segment   <= req_segment;
      stop      <= 1'b0;
      loop_cnt  <= rep;
      idx_0_out <= idx_0_in;
      idx_1_out <= idx_1_in;
    end else if (!stop) begin
      if (wrap && loop_cnt == 16'd0) begin
        // last loop done, hold the final pattern.
        stop <= 1'b1;
      end else begin
        idx_0_out <= idx_0_in;
        idx_1_out <= idx_1_in;
        if (wrap && loop_cnt != REP_INFINITE) begin
          loop_cnt <= loop_cnt - 16'd1;
        end
      end
    end
  end

endmodule

// File: verilog/stm_gain.sv
`timescale 1ns/1ns
module stm_gain #(
  parameter int DEPTH    = 249,
  parameter int PATTERNS = 8
) (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [15:0]                 idx,
  input  logic                        segment,
  input  logic                        gain_wr_en,
  input  logic                        gain_wr_segment,
  input  logic [$clog2(PATTERNS)-1:0] gain_wr_pattern,
  input  logic [$clog2(DEPTH)-1:0]    gain_wr_trans,
  input  logic [15:0]                 gain_wr_data,
  output logic [7:0]                  intensity,
  output logic [7:0]                  phase,
  output logic                        dout_valid
);

  localparam int PW    = $clog2(PATTERNS);
  localparam int TW    = $clog2(DEPTH);
  localparam int WORDS = 2 * PATTERNS * DEPTH;
  localparam int AW    = $clog2(WORDS);

  logic [15:0]   mem [WORDS];
  logic [15:0]   rd_data;
  logic [AW-1:0] base;
  logic [AW-1:0] rd_addr;
  logic [AW-1:0] wr_addr;
  logic [TW-1:0] trans;
  logic          busy;

  // one block of DEPTH words per segment and pattern.
  assign base    = AW'((int'(segment) * PATTERNS + int'(idx[PW-1:0])) * DEPTH);
  assign rd_addr = base + AW'(trans);
  assign wr_addr = AW'((int'(gain_wr_segment) * PATTERNS + int'(gain_wr_pattern)) * DEPTH
                       + int'(gain_wr_trans));

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      trans      <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= busy;
      if (start) begin
        busy  <= 1'b1;
        trans <= '0;
      end else if (busy) begin
        if (trans == TW'(DEPTH - 1)) begin
          busy <= 1'b0;
        end
        trans <= trans + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (gain_wr_en) begin
      mem[wr_addr] <= gain_wr_data;
    end
    rd_data <= mem[rd_addr];
  end

  // intensity in the high byte.
  assign intensity = rd_data[15:8];
  assign phase     = rd_data[7:0];

endmodule

// File: verilog/stm_focus.sv
`timescale 1ns/1ns
module stm_focus #(
  parameter int DEPTH    = 249,
  parameter int COLS     = 18,
  parameter int PATTERNS = 8
) (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [15:0]                 idx,
  input  logic                        segment,
  input  logic [15:0]                 sound_speed,
  input  logic                        focus_wr_en,
  input  logic                        focus_wr_segment,
  input  logic [$clog2(PATTERNS)-1:0] focus_wr_pattern,
  input  logic [55:0]                 focus_wr_data,
  output logic [7:0]                  intensity,
  output logic [7:0]                  phase,
  output logic                        dout_valid
);

  import stm_pkg::*;

  localparam int PW = $clog2(PATTERNS);

  logic [55:0]        fmem [2*PATTERNS];
  logic [55:0]        point;
  focus_state_t       state;
  logic [15:0]        col;
  logic [15:0]        row;
  logic [15:0]        trans;
  logic signed [15:0] fx;
  logic signed [15:0] fy;
  logic signed [15:0] fz;
  logic signed [17:0] px;
  logic signed [17:0] py;
  logic signed [17:0] dx;
  logic signed [17:0] dy;
  logic signed [17:0] dz;
  logic signed [35:0] dx2;
  logic signed [35:0] dy2;
  logic signed [35:0] dz2;
  logic [36:0]        d2;
  logic [31:0]        sq;
  logic [15:0]        root;
  logic [15:0]        trial;
  logic [31:0]        trial_sq;
  logic [3:0]         bit_idx;
  logic [31:0]        prod;

  // point word is x, y, z, then intensity.
  assign fx = point[55:40];
  assign fy = point[39:24];
  assign fz = point[23:8];

  // transducer sits on the z = 0 plane.
  assign px  = signed'({2'b00, 16'(col * PITCH)});
  assign py  = signed'({2'b00, 16'(row * PITCH)});
  assign dx  = px - fx;
  assign dy  = py - fy;
  assign dz  = 18'sd0 - fz;
  assign dx2 = dx * dx;
  assign dy2 = dy * dy;
  assign dz2 = dz * dz;
  assign d2  = 37'(dx2) + 37'(dy2) + 37'(dz2);

  // restoring square root, msb first.
  assign trial    = root | (16'd1 << bit_idx);
  assign trial_sq = 32'(trial) * 32'(trial);
  assign prod     = 32'(root) * 32'(sound_speed);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state      <= FOCUS_IDLE;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= 1'b0;
      case (state)
        FOCUS_IDLE: begin
          if (start) begin
            col   <= 16'd0;
            row   <= 16'd0;
            trans <= 16'd0;
            state <= FOCUS_LOAD;
          end
        end
        FOCUS_LOAD: begin
          state <= FOCUS_SQUARE;
        end
        FOCUS_SQUARE: begin
          sq      <= d2[31:0];
          root    <= 16'd0;
          bit_idx <= 4'd15;
          state   <= FOCUS_ROOT;
        end
        FOCUS_ROOT: begin
          if (trial_sq <= sq) begin
            root <= trial;
          end
          if (bit_idx == 4'd0) begin
            state <= FOCUS_EMIT;
          end else begin
            bit_idx <= bit_idx - 4'd1;
          end
        end
        FOCUS_EMIT: begin
          intensity  <= point[7:0];
          phase      <= prod[15:8];
          dout_valid <= 1'b1;
          if (trans == 16'(DEPTH - 1)) begin
            state <= FOCUS_IDLE;
          end else begin
            trans <= trans + 16'd1;
            state <= FOCUS_SQUARE;
            // next grid position, row by row.
            if (col == 16'(COLS - 1)) begin
              col <= 16'd0;
              row <= row + 16'd1;
            end else begin
              col <= col + 16'd1;
            end
          end
        end
        default: begin
          state <= FOCUS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (focus_wr_en) begin
      fmem[{focus_wr_segment, focus_wr_pattern}] <= focus_wr_data;
    end
    if (state == FOCUS_LOAD) begin
      point <= fmem[{segment, idx[PW-1:0]}];
    end
  end

endmodule

// File: verilog/stm.sv
`timescale 1ns/1ns
module stm #(
  parameter int DEPTH    = 249,
  parameter int COLS     = 18,
  parameter int PATTERNS = 8
) (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        update,
  input  logic                        settings_update,
  input  stm_pkg::stm_mode_t          req_mode,
  input  logic                        req_segment,
  input  logic [15:0]                 rep,
  input  logic [15:0]                 cycle_0,
  input  logic [15:0]                 cycle_1,
  input  logic [15:0]                 freq_div_0,
  input  logic [15:0]                 freq_div_1,
  input  logic [15:0]                 sound_speed,
  input  logic                        gain_wr_en,
  input  logic                        gain_wr_segment,
  input  logic [$clog2(PATTERNS)-1:0] gain_wr_pattern,
  input  logic [$clog2(DEPTH)-1:0]    gain_wr_trans,
  input  logic [15:0]                 gain_wr_data,
  input  logic                        focus_wr_en,
  input  logic                        focus_wr_segment,
  input  logic [$clog2(PATTERNS)-1:0] focus_wr_pattern,
  input  logic [55:0]                 focus_wr_data,
  output logic [7:0]                  intensity,
  output logic [7:0]                  phase,
  output logic                        dout_valid,
  output logic [15:0]                 debug_idx,
  output logic                        debug_segment
);

  import stm_pkg::*;

  logic [15:0] idx_0;
  logic [15:0] idx_1;
  logic        sw_update;
  stm_mode_t   sw_mode;
  logic        sw_segment;
  logic        stop;
  logic [15:0] sw_idx_0;
  logic [15:0] sw_idx_1;
  stm_mode_t   lat_mode;
  logic        lat_segment;
  logic [15:0] lat_idx;
  logic        start;
  logic        gain_start;
  logic        focus_start;
  logic [7:0]  gain_intensity;
  logic [7:0]  gain_phase;
  logic        gain_valid;
  logic [7:0]  focus_intensity;
  logic [7:0]  focus_phase;
  logic        focus_valid;

  stm_timer stm_timer_i (
    .CLK                 (CLK),
    .rst_n               (rst_n),
    .settings_update     (settings_update),
    .cycle_0             (cycle_0),
    .cycle_1             (cycle_1),
    .freq_div_0          (freq_div_0),
    .freq_div_1          (freq_div_1),
    .idx_0               (idx_0),
    .idx_1               (idx_1),
    .settings_update_out (sw_update)
  );

  stm_swapchain stm_swapchain_i (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .settings_update (sw_update),
    .req_mode        (req_mode),
    .req_segment     (req_segment),
    .rep             (rep),
    .idx_0_in        (idx_0),
    .idx_1_in        (idx_1),
    .mode            (sw_mode),
    .segment         (sw_segment),
    .stop            (stop),
    .idx_0_out       (sw_idx_0),
    .idx_1_out       (sw_idx_1)
  );

  // frame state freezes once the repeats run out.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      lat_mode    <= STM_MODE_GAIN;
      lat_segment <= 1'b0;
      lat_idx     <= 16'd0;
      start       <= 1'b0;
    end else begin
      start <= update;
      if (update && !stop) begin
        lat_mode    <= sw_mode;
        lat_segment <= sw_segment;
        lat_idx     <= sw_segment ? sw_idx_1 : sw_idx_0;
      end
    end
  end

  assign debug_idx     = lat_idx;
  assign debug_segment = lat_segment;
  assign gain_start    = start && (lat_mode == STM_MODE_GAIN);
  assign focus_start   = start && (lat_mode == STM_MODE_FOCUS);

  stm_gain #(.DEPTH(DEPTH), .PATTERNS(PATTERNS)) stm_gain_i (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .start           (gain_start),
    .idx             (lat_idx),
    .segment         (lat_segment),
    .gain_wr_en      (gain_wr_en),
    .gain_wr_segment (gain_wr_segment),
    .gain_wr_pattern (gain_wr_pattern),
    .gain_wr_trans   (gain_wr_trans),
    .gain_wr_data    (gain_wr_data),
    .intensity       (gain_intensity),
    .phase           (gain_phase),
    .dout_valid      (gain_valid)
  );

  stm_focus #(.DEPTH(DEPTH), .COLS(COLS), .PATTERNS(PATTERNS)) stm_focus_i (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .start            (focus_start),
    .idx              (lat_idx),
    .segment          (lat_segment),
    .sound_speed      (sound_speed),
    .focus_wr_en      (focus_wr_en),
    .focus_wr_segment (focus_wr_segment),
    .focus_wr_pattern (focus_wr_pattern),
    .focus_wr_data    (focus_wr_data),
    .intensity        (focus_intensity),
    .phase            (focus_phase),
    .dout_valid       (focus_valid)
  );

  // output follows the generator of the latched mode.
  assign intensity  = (lat_mode == STM_MODE_FOCUS) ? focus_intensity : gain_intensity;
  assign phase      = (lat_mode == STM_MODE_FOCUS) ? focus_phase : gain_phase;
  assign dout_valid = (lat_mode == STM_MODE_FOCUS) ? focus_valid : gain_valid;

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ns
module clock_gen (
  output logic CLK,
  output logic rst_n
);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // reset held low for four rising edges.
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge CLK);
    #5 rst_n = 1'b1;
  end

endmodule

// File: tests/stm_tb.sv
`timescale 1ns/1ns
module stm_tb;

  import stm_pkg::*;

  localparam int DEPTH    = 6;
  localparam int COLS     = 3;
  localparam int PATTERNS = 8;
  localparam int PW       = $clog2(PATTERNS);
  localparam int TW       = $clog2(DEPTH);
  // memory writes, 26 gain frames with gaps, 4 focus frames.
  localparam int PLAN_CYCLES = 2 * PATTERNS * (DEPTH + 1) + 26 * (DEPTH + 10)
                               + 4 * (20 * DEPTH + 4) + 40;
  localparam int MAX_CYCLES  = 2 * PLAN_CYCLES;

  logic              CLK;
  logic              rst_n;
  logic              update;
  logic              settings_update;
  stm_mode_t         req_mode;
  logic              req_segment;
  logic [15:0]       rep;
  logic [15:0]       cycle_0;
  logic [15:0]       cycle_1;
  logic [15:0]       freq_div_0;
  logic [15:0]       freq_div_1;
  logic [15:0]       sound_speed;
  logic              gain_wr_en;
  logic              gain_wr_segment;
  logic [PW-1:0]     gain_wr_pattern;
  logic [TW-1:0]     gain_wr_trans;
  logic [15:0]       gain_wr_data;
  logic              focus_wr_en;
  logic              focus_wr_segment;
  logic [PW-1:0]     focus_wr_pattern;
  logic [55:0]       focus_wr_data;
  logic [7:0]        intensity;
  logic [7:0]        phase;
  logic              dout_valid;
  logic [15:0]       debug_idx;
  logic              debug_segment;

  // reference model state.
  logic [15:0]       gmem [2][PATTERNS][DEPTH];
  logic [55:0]       fmem [2][PATTERNS];
  logic [31:0]       lfsr = 32'hed67_9ebf;
  int                cycles = 0;
  int                cnt = 0;
  int                since = 0;
  int                beat = 0;
  int                frames = 0;
  logic [15:0]       r_cycle [2] = '{16'd1, 16'd1};
  logic [15:0]       r_div [2] = '{16'd1, 16'd1};
  stm_mode_t         r_mode = STM_MODE_GAIN;
  logic              r_seg = 1'b0;
  logic [15:0]       r_rep = REP_INFINITE;
  logic              sup_seen = 1'b0;
  stm_mode_t         m_mode = STM_MODE_GAIN;
  logic              m_seg = 1'b0;
  logic              m_stop = 1'b0;
  logic [15:0]       loops = REP_INFINITE;
  logic [15:0]       sw_idx [2] = '{16'd0, 16'd0};
  stm_mode_t         exp_mode = STM_MODE_GAIN;
  logic              exp_seg = 1'b0;
  logic [15:0]       exp_idx = 16'd0;
  logic              latched = 1'b0;

  clock_gen clock_gen_i (.CLK(CLK), .rst_n(rst_n));

  stm #(.DEPTH(DEPTH), .COLS(COLS), .PATTERNS(PATTERNS)) stm_i (.*);

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t ns: %s", $time, what);
    abort_run();
  endtask

  // galois lfsr, one step per bit taken.
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] timer_idx(input logic s);
    return 16'((cnt / int'(r_div[s])) % int'(r_cycle[s]));
  endfunction

  // intensity and phase of one beat of the latched frame.
  function automatic logic [15:0] expected_pair(input int b);
    logic [55:0] pt;
    int          dx;
    int          dy;
    int          dz;
    int          d2;
    int          r;
    logic [31:0] prod;
    if (exp_mode == STM_MODE_GAIN) begin
      return gmem[exp_seg][int'(exp_idx) % PATTERNS][b];
    end
    pt = fmem[exp_seg][int'(exp_idx) % PATTERNS];
    dx = (b % COLS) * int'(PITCH) - int'(signed'(pt[55:40]));
    dy = (b / COLS) * int'(PITCH) - int'(signed'(pt[39:24]));
    dz = int'(signed'(pt[23:8]));
    d2 = dx * dx + dy * dy + dz * dz;
    r = 0;
    while ((r + 1) * (r + 1) <= d2) begin
      r++;
    end
    prod = 32'(r) * 32'(sound_speed);
    return {pt[7:0], prod[15:8]};
  endfunction

  always @(posedge CLK) begin : check
    logic [15:0] pair;
    logic        wrap;
    if (rst_n) begin
      since++;
      assert (!$isunknown(dout_valid)) else value_error("dout_valid", dout_valid, 1'b0);
      if (!latched) begin
        assert (dout_valid === 1'b0) else value_error("dout_valid", dout_valid, 1'b0);
        assert (debug_segment === 1'b0) else value_error("debug_segment", debug_segment, 0);
      end else begin
        assert (debug_idx === exp_idx) else value_error("debug_idx", debug_idx, exp_idx);
        assert (debug_segment === exp_seg)
          else value_error("debug_segment", debug_segment, exp_seg);
      end
      if (dout_valid) begin
        assert (beat < DEPTH) else report_failure("dout_valid pulsed after the last transducer");
        // gain beats follow start by two cycles, back to back.
        if (exp_mode == STM_MODE_GAIN) begin
          assert (since == beat + 3)
            else report_failure($sformatf("gain beat %0d came %0d cycles after update",
                                          beat, since));
        end
        pair = expected_pair(beat);
        assert (intensity === pair[15:8]) else value_error("intensity", intensity, pair[15:8]);
        assert (phase === pair[7:0]) else value_error("phase", phase, pair[7:0]);
        beat++;
      end
      if (update) begin
        if (!m_stop) begin
          exp_mode = m_mode;
          exp_seg  = m_seg;
          exp_idx  = sw_idx[m_seg];
          latched  = 1'b1;
        end
        beat   = 0;
        since  = 0;
        frames++;
      end
      // swapchain runs one edge behind the timer.
      if (sup_seen) begin
        m_mode    = r_mode;
        m_seg     = r_seg;
        loops     = r_rep;
        m_stop    = 1'b0;
        sw_idx[0] = timer_idx(1'b0);
        sw_idx[1] = timer_idx(1'b1);
      end else if (!m_stop) begin
        wrap = timer_idx(m_seg) < sw_idx[m_seg];
        if (wrap && loops == 16'd0) begin
          m_stop = 1'b1;
        end else begin
          if (wrap && loops != REP_INFINITE) begin
            loops--;
          end
          sw_idx[0] = timer_idx(1'b0);
          sw_idx[1] = timer_idx(1'b1);
        end
      end
      sup_seen = settings_update;
      if (settings_update) begin
        cnt        = 0;
        r_cycle[0] = cycle_0;
        r_cycle[1] = cycle_1;
        r_div[0]   = freq_div_0;
        r_div[1]   = freq_div_1;
        r_mode     = req_mode;
        r_seg      = req_segment;
        r_rep      = rep;
      end else begin
        cnt++;
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      report_failure($sformatf("timeout, run still going after %0d cycles", cycles));
    end
  end

  task automatic fill_memories();
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < PATTERNS; p++) begin
        for (int t = 0; t < DEPTH; t++) begin
          gain_wr_en      = 1'b1;
          gain_wr_segment = s[0];
          gain_wr_pattern = PW'(p);
          gain_wr_trans   = TW'(t);
          gain_wr_data    = 16'(random_bits(16));
          gmem[s][p][t]   = gain_wr_data;
          @(posedge CLK);
          #5;
        end
        gain_wr_en       = 1'b0;
        focus_wr_en      = 1'b1;
        focus_wr_segment = s[0];
        focus_wr_pattern = PW'(p);
        // coordinates kept within 0 to 63.
        focus_wr_data    = {16'(random_bits(6)), 16'(random_bits(6)), 16'(random_bits(6)),
                            8'(random_bits(8))};
        fmem[s][p]       = focus_wr_data;
        @(posedge CLK);
        #5;
        focus_wr_en = 1'b0;
      end
    end
  endtask

  task automatic apply_settings(input stm_mode_t m, input logic s, input logic [15:0] count,
                                input logic [15:0] c0, input logic [15:0] d0,
                                input logic [15:0] c1, input logic [15:0] d1,
                                input logic [15:0] speed);
    req_mode        = m;
    req_segment     = s;
    rep             = count;
    cycle_0         = c0;
    freq_div_0      = d0;
    cycle_1         = c1;
    freq_div_1      = d1;
    sound_speed     = speed;
    settings_update = 1'b1;
    @(posedge CLK);
    #5;
    settings_update = 1'b0;
    repeat (2) @(posedge CLK);
    #5;
  endtask

  task automatic run_frame(input int gap);
    update = 1'b1;
    @(posedge CLK);
    #5;
    update = 1'b0;
    while (beat < DEPTH) begin
      @(posedge CLK);
      #5;
    end
    repeat (gap) @(posedge CLK);
    #5;
  endtask

  initial begin
    update           = 1'b0;
    settings_update  = 1'b0;
    req_mode         = STM_MODE_GAIN;
    req_segment      = 1'b0;
    rep              = REP_INFINITE;
    cycle_0          = 16'd1;
    cycle_1          = 16'd1;
    freq_div_0       = 16'd1;
    freq_div_1       = 16'd1;
    sound_speed      = 16'd0;
    gain_wr_en       = 1'b0;
    gain_wr_segment  = 1'b0;
    gain_wr_pattern  = '0;
    gain_wr_trans    = '0;
    gain_wr_data     = 16'd0;
    focus_wr_en      = 1'b0;
    focus_wr_segment = 1'b0;
    focus_wr_pattern = '0;
    focus_wr_data    = 56'd0;
    wait (rst_n === 1'b1);
    repeat (2) @(posedge CLK);
    #5;
    fill_memories();
    apply_settings(STM_MODE_GAIN, 1'b0, REP_INFINITE, 16'd5, 16'd3, 16'd7, 16'd2, 16'd0);
    repeat (8) run_frame(int'(random_bits(3)));
    apply_settings(STM_MODE_GAIN, 1'b1, REP_INFINITE, 16'd5, 16'd3, 16'd4, 16'd2, 16'd0);
    repeat (6) run_frame(int'(random_bits(3)));
    // two loops of three patterns, then frozen on the last one.
    apply_settings(STM_MODE_GAIN, 1'b0, 16'd1, 16'd3, 16'd10, 16'd4, 16'd2, 16'd0);
    repeat (12) run_frame(0);
    assert (m_stop) else report_failure("finite repeat count never stopped the sequence");
    assert (debug_idx === 16'd2) else value_error("debug_idx", debug_idx, 16'd2);
    apply_settings(STM_MODE_FOCUS, 1'b1, REP_INFINITE, 16'd5, 16'd3, 16'd4, 16'd5, 16'd587);
    repeat (4) run_frame(int'(random_bits(3)));
    if (frames == 30 && beat == DEPTH) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      report_failure($sformatf("run ended after %0d frames, last one with %0d beats",
                               frames, beat));
    end
  end

endmodule

// File: verilog.f
verilog/stm_pkg.sv
verilog/stm_timer.sv
verilog/stm_swapchain.sv
verilog/stm_gain.sv
verilog/stm_focus.sv
verilog/stm.sv
tests/clock_gen.sv
tests/stm_tb.sv
